/* lsu.f */
lsu_pkg.sv
lsu_agu.sv
lsu_req_fifo.sv
lsu_mem_unit.sv
lsu_top.sv
tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lsu testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f lsu.f -o sim_lsu
# the log decides pass or fail
./obj_dir/sim_lsu > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* tb_lsu.sv */
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned MEM_WORDS  = 16;
    localparam int unsigned FIFO_DEPTH = 4;

    typedef struct {
        logic                  stall;
        logic                  flush;
        logic                  valid;
        lsu_op_e               op;
        logic [XLEN-1:0]       base;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       wdata;
        logic [TRANS_ID_W-1:0] tid;
        logic [XLEN-1:0]       exp_val;
    } row_t;

    // accepted request still waiting for its result
    typedef struct {
        lsu_op_e               op;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       wdata;
        logic [TRANS_ID_W-1:0] tid;
        logic [XLEN-1:0]       exp_val;
    } pending_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        flush;
    logic        stall;
    logic        req_valid;
    lsu_req_t    req;
    logic        ready;
    lsu_result_t load_res;
    lsu_result_t store_res;

    row_t            rows[$];
    pending_t        exp_q[$];
    logic [XLEN-1:0] model_mem [MEM_WORDS] = '{default: '0};
    int              occ = 0;
    logic            pop_seen = 1'b0;
    logic            accepted;
    int              cycles = 0;
    int              cycle_limit = 100;

    lsu_top i_dut (
        .clk_i       ( clk       ),
        .rst_ni      ( rst_n     ),
        .flush_i     ( flush     ),
        .stall_i     ( stall     ),
        .req_valid_i ( req_valid ),
        .req_i       ( req       ),
        .ready_o     ( ready     ),
        .load_o      ( load_res  ),
        .store_o     ( store_res )
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp)
            else abort_run($sformatf("ERROR: %s is 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    function automatic logic is_store_op(input lsu_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    // ------------------------------------------------------------
    // reference model of the scratchpad
    // ------------------------------------------------------------
    function automatic lsu_result_t predict_result(input pending_t p);
        lsu_result_t     r;
        logic            st;
        int unsigned     nbytes;
        int unsigned     lane;
        logic [XLEN-1:0] w;
        r          = '0;
        r.valid    = 1'b1;
        r.trans_id = p.tid;
        st         = is_store_op(p.op);
        nbytes     = (p.op inside {LB, LBU, SB}) ? 1 : (p.op inside {LH, LHU, SH}) ? 2 : 4;
        lane       = p.addr[1:0];
        // range fault first, then alignment
        if ((p.addr >> 2) >= MEM_WORDS) begin
            r.ex = '{1'b1, st ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS, p.addr};
        end else if ((lane % nbytes) != 0) begin
            r.ex = '{1'b1, st ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED, p.addr};
        end else begin
            w = model_mem[p.addr >> 2];
            if (st) begin
                for (int k = 0; k < nbytes; k++) begin
                    w[8*(lane+k) +: 8] = p.wdata[8*k +: 8];
                end
                model_mem[p.addr >> 2] = w;
            end else begin
                case (p.op)
                    LB:      r.result = {{24{w[8*lane+7]}}, w[8*lane +: 8]};
                    LBU:     r.result = {24'b0, w[8*lane +: 8]};
                    LH:      r.result = {{16{w[8*lane+15]}}, w[8*lane +: 16]};
                    LHU:     r.result = {16'b0, w[8*lane +: 16]};
                    default: r.result = w;
                endcase
            end
        end
        return r;
    endfunction

    task automatic check_results();
        pending_t    p;
        lsu_result_t exp_r;
        lsu_result_t got;
        logic        st;
        string       port;
        if (!pop_seen) begin
            assert (!load_res.valid && !store_res.valid)
                else abort_run("a result appeared although no request was executed");
        end else begin
            assert (exp_q.size() != 0)
                else abort_run("a request was executed although none was expected");
            p     = exp_q.pop_front();
            st    = is_store_op(p.op);
            exp_r = predict_result(p);
            port  = st ? "store_o" : "load_o";
            got   = st ? store_res : load_res;
            assert (load_res.valid == !st && store_res.valid == st)
                else abort_run($sformatf("trans_id %0d did not return on %s alone", p.tid, port));
            assert (exp_r.result == p.exp_val)
                else abort_run($sformatf("model and table disagree for trans_id %0d", p.tid));
            check_value({port, ".trans_id"}, 32'(got.trans_id), 32'(exp_r.trans_id));
            check_value({port, ".result"}, got.result, exp_r.result);
            check_value({port, ".ex.valid"}, 32'(got.ex.valid), 32'(exp_r.ex.valid));
            check_value({port, ".ex.cause"}, 32'(got.ex.cause), 32'(exp_r.ex.cause));
            check_value({port, ".ex.tval"}, got.ex.tval, exp_r.ex.tval);
        end
    endtask

    task automatic drive_row(input row_t r);
        stall     = r.stall;
        flush     = r.flush;
        req_valid = r.valid;
        req       = '{op: r.op, operand_a: r.base, imm: r.imm, wdata: r.wdata,
                      trans_id: r.tid};
    endtask

    // check at the falling edge, then track buffer and queue over the rising edge
    task automatic step_cycle(input row_t r);
        logic     pop_now;
        pending_t p;
        @(negedge clk);
        check_results();
        check_value("ready_o", 32'(ready), 32'(occ != FIFO_DEPTH));
        accepted = r.valid && ready && !r.flush;
        pop_now  = (occ != 0) && !r.stall && !r.flush;
        @(posedge clk);
        if (r.flush) begin
            occ = 0;
            exp_q.delete();
        end else begin
            if (accepted) begin
                p = '{r.op, r.base + r.imm, r.wdata, r.tid, r.exp_val};
                exp_q.push_back(p);
            end
            occ = occ + (accepted ? 1 : 0) - (pop_now ? 1 : 0);
        end
        pop_seen = pop_now;
        #1;
    endtask

    task automatic add_row(input int stall_lvl, input lsu_op_e op, input logic [XLEN-1:0] base,
                           input logic [XLEN-1:0] imm, input logic [XLEN-1:0] wdata,
                           input int tid, input logic [XLEN-1:0] exp_val);
        row_t r;
        r = '{stall_lvl != 0, 1'b0, 1'b1, op, base, imm, wdata, TRANS_ID_W'(tid), exp_val};
        rows.push_back(r);
    endtask

    task automatic add_idle(input int stall_lvl, input int flush_lvl, input int n);
        row_t r;
        r = '{stall_lvl != 0, flush_lvl != 0, 1'b0, LB, '0, '0, '0, '0, '0};
        repeat (n) rows.push_back(r);
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    task automatic build_table();
        // word store and load, unwritten word
        add_row(0, LW,  32'h10, 0, 32'h0, 0, 32'h0);
        add_row(0, SW,  32'h10, 4, 32'hdeadbeef, 1, 32'h0);
        add_row(0, LW,  32'h14, 0, 32'h0, 2, 32'hdeadbeef);
        // byte and halfword lanes, sign and zero extension
        add_row(0, SW,  32'h20, 0, 32'h11223344, 3, 32'h0);
        add_row(0, SB,  32'h21, 0, 32'h000000a5, 4, 32'h0);
        add_row(0, SH,  32'h22, 0, 32'h0000f00d, 5, 32'h0);
        add_row(0, LB,  32'h21, 0, 32'h0, 6, 32'hffffffa5);
        add_row(0, LBU, 32'h21, 0, 32'h0, 7, 32'h000000a5);
        add_row(0, LH,  32'h22, 0, 32'h0, 0, 32'hfffff00d);
        add_row(0, LHU, 32'h22, 0, 32'h0, 1, 32'h0000f00d);
        add_row(0, LW,  32'h20, 0, 32'h0, 2, 32'hf00da544);
        add_row(0, LB,  32'h20, 0, 32'h0, 3, 32'h00000044);
        add_row(0, LH,  32'h24, -4, 32'h0, 4, 32'hffffa544);
        // misaligned accesses leave memory alone
        add_row(0, SW,  32'h30, 1, 32'hcafef00d, 5, 32'h0);
        add_row(0, SH,  32'h33, 0, 32'h00001234, 6, 32'h0);
        add_row(0, LH,  32'h25, 0, 32'h0, 7, 32'h0);
        add_row(0, LW,  32'h22, 0, 32'h0, 0, 32'h0);
        add_row(0, LW,  32'h30, 0, 32'h0, 1, 32'h0);
        // past the end of the scratchpad
        add_row(0, LW,  32'h40, 0, 32'h0, 2, 32'h0);
        add_row(0, SB,  32'h43, 0, 32'h000000ff, 3, 32'h0);
        add_row(0, LH,  32'h41, 0, 32'h0, 4, 32'h0);
        add_row(0, SW,  32'hfffffffc, 0, 32'h1, 5, 32'h0);
        // the words that the faulting stores alias stay untouched
        add_row(0, LW,  32'h00, 0, 32'h0, 6, 32'h0);
        add_row(0, LW,  32'h3c, 0, 32'h0, 7, 32'h0);
        add_row(0, SW,  32'h3c, 0, 32'h0badcafe, 6, 32'h0);
        add_row(0, LW,  32'h3c, 0, 32'h0, 7, 32'h0badcafe);
        add_idle(0, 0, 2);
        // stall fills the buffer until ready_o drops
        add_row(1, SW,  32'h08, 0, 32'h55667788, 0, 32'h0);
        add_row(1, LW,  32'h08, 0, 32'h0, 1, 32'h55667788);
        add_row(1, SB,  32'h0b, 0, 32'h00000099, 2, 32'h0);
        add_row(1, LW,  32'h08, 0, 32'h0, 3, 32'h99667788);
        add_idle(1, 0, 2);
        add_row(0, LBU, 32'h0b, 0, 32'h0, 4, 32'h00000099);
        add_idle(0, 0, 4);
        // flush while stalled drops the queued requests
        add_row(1, SW,  32'h0c, 0, 32'h12345678, 5, 32'h0);
        add_row(1, LW,  32'h0c, 0, 32'h0, 6, 32'h12345678);
        add_row(1, SW,  32'h08, 0, 32'hffffffff, 7, 32'h0);
        add_idle(1, 1, 1);
        add_row(0, LW,  32'h0c, 0, 32'h0, 0, 32'h0);
        add_row(0, LW,  32'h08, 0, 32'h0, 1, 32'h99667788);
        add_idle(0, 0, 2);
    endtask

    initial begin
        row_t idle;
        idle      = '{1'b0, 1'b0, 1'b0, LB, '0, '0, '0, '0, '0};
        rst_n     = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        cycle_limit = 20 * rows.size() + 100;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            drive_row(rows[i]);
            step_cycle(rows[i]);
            // hold a request until the buffer takes it
            while (rows[i].valid && !accepted) begin
                step_cycle(rows[i]);
            end
        end
        drive_row(idle);
        while (exp_q.size() != 0) begin
            step_cycle(idle);
        end
        repeat (3) step_cycle(idle);
        if (exp_q.size() != 0 || occ != 0) begin
            abort_run($sformatf("%0d results never arrived", exp_q.size()));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* lsu_top.sv */
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int unsigned MEM_WORDS  = 16,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  wire logic   clk_i,
    input  wire logic   rst_ni,
    input  wire logic   flush_i,
    input  wire logic   stall_i,
    input  wire logic   req_valid_i,
    input  lsu_req_t    req_i,
    output logic        ready_o,
    output lsu_result_t load_o,
    output lsu_result_t store_o
);

    lsu_ctrl_t agu_ctrl;
    lsu_ctrl_t head_ctrl;
    logic      head_valid;
    logic      pop;

    // ------------------------------------------------------------
    // address generation, decode and checks
    // ------------------------------------------------------------
    lsu_agu #(
        .MEM_WORDS ( MEM_WORDS )
    ) i_agu (
        .req_i  ( req_i    ),
        .ctrl_o ( agu_ctrl )
    );

    // ------------------------------------------------------------
    // request buffer
    // ------------------------------------------------------------
    lsu_req_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) i_req_fifo (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .flush_i     ( flush_i     ),
        .push_i      ( req_valid_i ),
        .data_i      ( agu_ctrl    ),
        .ready_o     ( ready_o     ),
        .pop_i       ( pop         ),
        .not_empty_o ( head_valid  ),
        .data_o      ( head_ctrl   )
    );

    // ------------------------------------------------------------
    // scratchpad access and write-back
    // ------------------------------------------------------------
    lsu_mem_unit #(
        .MEM_WORDS ( MEM_WORDS )
    ) i_mem_unit (
        .clk_i   ( clk_i      ),
        .rst_ni  ( rst_ni     ),
        .stall_i ( stall_i    ),
        .valid_i ( head_valid ),
        .ctrl_i  ( head_ctrl  ),
        .pop_o   ( pop        ),
        .load_o  ( load_o     ),
        .store_o ( store_o    )
    );

endmodule

`default_nettype wire

/* lsu_mem_unit.sv */
`default_nettype none

module lsu_mem_unit import lsu_pkg::*; #(
    parameter int unsigned MEM_WORDS = 16
) (
    input  wire logic   clk_i,
    input  wire logic   rst_ni,
    input  wire logic   stall_i,
    input  wire logic   valid_i,
    input  lsu_ctrl_t   ctrl_i,
    output logic        pop_o,
    output lsu_result_t load_o,
    output lsu_result_t store_o
);

    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [XLEN-1:0]       mem_q [MEM_WORDS];
    logic [IDX_W-1:0]      idx;
    logic [XLEN-1:0]       rdata;
    logic [XLEN-1:0]       rdata_shift;
    logic [XLEN-1:0]       wdata_lane;
    logic [XLEN-1:0]       ld_value;
    logic                  do_write;

    logic                  load_valid_q;
    logic                  store_valid_q;
    logic [TRANS_ID_W-1:0] trans_id_q;
    logic [XLEN-1:0]       result_q;
    exception_t            ex_q;

    // one entry per cycle unless held off
    assign pop_o = valid_i && !stall_i;

    assign idx = ctrl_i.addr[IDX_W+1:2];

    // ------------------------------------------------------------
    // load path
    // ------------------------------------------------------------
    assign rdata       = mem_q[idx];
    assign rdata_shift = rdata >> {ctrl_i.addr[1:0], 3'b000};

    always_comb begin : ld_extend
        case (ctrl_i.op)
            LB:      ld_value = {{(XLEN-8){rdata_shift[7]}}, rdata_shift[7:0]};
            LH:      ld_value = {{(XLEN-16){rdata_shift[15]}}, rdata_shift[15:0]};
            LBU:     ld_value = {{(XLEN-8){1'b0}}, rdata_shift[7:0]};
            LHU:     ld_value = {{(XLEN-16){1'b0}}, rdata_shift[15:0]};
            LW:      ld_value = rdata;
            default: ld_value = '0;
        endcase
    end

    // ------------------------------------------------------------
    // store path
    // ------------------------------------------------------------
    // move store data onto the addressed lanes
    assign wdata_lane = ctrl_i.wdata << {ctrl_i.addr[1:0], 3'b000};
    assign do_write   = pop_o && ctrl_i.is_store && !ctrl_i.ex.valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (do_write) begin
            for (int b = 0; b < BE_W; b++) begin
                if (ctrl_i.be[b]) begin
                    mem_q[idx][8*b +: 8] <= wdata_lane[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // result registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            load_valid_q  <= 1'b0;
            store_valid_q <= 1'b0;
        end else begin
            load_valid_q  <= pop_o && !ctrl_i.is_store;
            store_valid_q <= pop_o && ctrl_i.is_store;
        end
    end

    // payload shared by both ports, the valid bit tells which one owns it
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            trans_id_q <= ctrl_i.trans_id;
            result_q   <= (ctrl_i.is_store || ctrl_i.ex.valid) ? '0 : ld_value;
            ex_q       <= ctrl_i.ex;
        end
    end

    assign load_o.valid     = load_valid_q;
    assign load_o.trans_id  = trans_id_q;
    assign load_o.result    = result_q;
    assign load_o.ex        = ex_q;

    assign store_o.valid    = store_valid_q;
    assign store_o.trans_id = trans_id_q;
    assign store_o.result   = result_q;
    assign store_o.ex       = ex_q;

endmodule

`default_nettype wire

/* lsu_req_fifo.sv */
`default_nettype none

module lsu_req_fifo import lsu_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire logic flush_i,
    input  wire logic push_i,
    input  lsu_ctrl_t data_i,
    output logic      ready_o,
    input  wire logic pop_i,
    output logic      not_empty_o,
    output lsu_ctrl_t data_o
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    lsu_ctrl_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_ok;
    logic             pop_ok;

    // wrap explicitly so that any depth works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign ready_o = (count_q != CNT_W'(FIFO_DEPTH));

    // head is withheld in the flush cycle, the whole content goes away
    assign not_empty_o = (count_q != '0) && !flush_i;
    assign data_o      = mem_q[rd_ptr_q];

    assign push_ok = push_i && ready_o && !flush_i;
    assign pop_ok  = pop_i && not_empty_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push_ok && !pop_ok) begin
                count_q <= count_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

/* lsu_agu.sv */
`default_nettype none

module lsu_agu import lsu_pkg::*; #(
    parameter int unsigned MEM_WORDS = 16
) (
    input  lsu_req_t  req_i,
    output lsu_ctrl_t ctrl_o
);

    // access size: 0 byte, 1 halfword, 2 word
    logic [1:0]      size;
    logic            is_store;
    logic [XLEN-1:0] addr;
    logic [BE_W-1:0] be;
    logic            misaligned;
    logic            out_of_range;
    exception_t      ex;

    // ------------------------------------------------------------
    // address generation
    // ------------------------------------------------------------
    assign addr = req_i.operand_a + req_i.imm;

    always_comb begin : op_decode
        size     = 2'd0;
        is_store = 1'b0;
        case (req_i.op)
            LB, LBU: size = 2'd0;
            LH, LHU: size = 2'd1;
            LW:      size = 2'd2;
            SB: begin
                size     = 2'd0;
                is_store = 1'b1;
            end
            SH: begin
                size     = 2'd1;
                is_store = 1'b1;
            end
            SW: begin
                size     = 2'd2;
                is_store = 1'b1;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // byte enable
    // ------------------------------------------------------------
    always_comb begin : be_gen
        case (size)
            2'd0:    be = 4'b0001 << addr[1:0];
            2'd1:    be = 4'b0011 << addr[1:0];
            default: be = 4'b1111;
        endcase
    end

    // ------------------------------------------------------------
    // address checks
    // ------------------------------------------------------------
    always_comb begin : align_check
        case (size)
            2'd1:    misaligned = addr[0];
            2'd2:    misaligned = (addr[1:0] != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end

    // word index past the end of the scratchpad
    assign out_of_range = ({2'b00, addr[XLEN-1:2]} >= MEM_WORDS);

    // access fault wins over misalignment
    always_comb begin : ex_gen
        ex = '0;
        if (out_of_range) begin
            ex.valid = 1'b1;
            ex.cause = is_store ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
            ex.tval  = addr;
        end else if (misaligned) begin
            ex.valid = 1'b1;
            ex.cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
            ex.tval  = addr;
        end
    end

    assign ctrl_o.op       = req_i.op;
    assign ctrl_o.addr     = addr;
    assign ctrl_o.wdata    = req_i.wdata;
    assign ctrl_o.be       = be;
    assign ctrl_o.trans_id = req_i.trans_id;
    assign ctrl_o.is_store = is_store;
    assign ctrl_o.ex       = ex;

endmodule

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned BE_W       = XLEN / 8;
    localparam int unsigned TRANS_ID_W = 3;

    // ------------------------------------------------------------
    // operations
    // ------------------------------------------------------------
    // bit 3 set for stores, low bits give size and signedness
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    // ------------------------------------------------------------
    // exception causes
    // ------------------------------------------------------------
    localparam logic [3:0] CAUSE_LD_MISALIGNED = 4'd4;
    localparam logic [3:0] CAUSE_LD_ACCESS     = 4'd5;
    localparam logic [3:0] CAUSE_ST_MISALIGNED = 4'd6;
    localparam logic [3:0] CAUSE_ST_ACCESS     = 4'd7;

    typedef struct packed {
        logic            valid;
        logic [3:0]      cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    // ------------------------------------------------------------
    // request, buffered control and result
    // ------------------------------------------------------------
    // incoming request as issued to the unit
    typedef struct packed {
        lsu_op_e               op;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       wdata;
        logic [TRANS_ID_W-1:0] trans_id;
    } lsu_req_t;

    // decoded request, held in the buffer
    typedef struct packed {
        lsu_op_e               op;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       wdata;
        logic [BE_W-1:0]       be;
        logic [TRANS_ID_W-1:0] trans_id;
        logic                  is_store;
        exception_t            ex;
    } lsu_ctrl_t;

    // write-back to the scoreboard side
    typedef struct packed {
        logic                  valid;
        logic [TRANS_ID_W-1:0] trans_id;
        logic [XLEN-1:0]       result;
        exception_t            ex;
    } lsu_result_t;

endpackage

`default_nettype wire
